// File: hdl/dcacheGeomPkg.sv
`default_nettype none

package dcacheGeomPkg;

    // byte address and line geometry
    localparam int AddrBits = 16;
    localparam int OffsetBits = 4;
    localparam int WordBits = 32;
    localparam int BytesPerWord = WordBits / 8;
    localparam int WordsPerBlock = 4;

    typedef logic [AddrBits-1:0] addr_t;
    typedef logic [WordBits-1:0] word_t;
    typedef logic [WordsPerBlock*WordBits-1:0] block_t;

    // bit i enables byte i of the word
    typedef logic [BytesPerWord-1:0] byteSel_t;

    // address without the offset that also serves as the Wishbone address
    typedef logic [AddrBits-OffsetBits-1:0] blockAddr_t;

    // word position inside a line
    typedef logic [$clog2(WordsPerBlock)-1:0] wordSel_t;

    // one load/store from the pipeline
    typedef struct packed {
        logic read;
        logic write;
        addr_t addr;
        byteSel_t byteSel;
        word_t wdata;
    } cpuReq_t;

endpackage

`default_nettype wire

// File: hdl/dcacheBusPkg.sv
`default_nettype none

package dcacheBusPkg;

    import dcacheGeomPkg::*;

    // Wishbone classic master outputs carrying one block per cycle
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        blockAddr_t adr;
        block_t dat;
    } wbMaster_t;

    // slave response without err or rty
    typedef struct packed {
        logic ack;
        block_t dat;
    } wbSlave_t;

    // array update commands from the controller
    typedef struct packed {
        logic hitWrite;
        logic fill;
    } arrayCtl_t;

    typedef enum logic [1:0] {
        Idle,
        WriteBack,
        MemRead,
        Fill
    } missState_t;

endpackage

`default_nettype wire

// File: hdl/dcacheArray.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheArray import dcacheGeomPkg::*, dcacheBusPkg::*; #(
    parameter int NumSets = 16
) (
    input  wire        clock,
    input  wire        reset,
    input  wire cpuReq_t   req,
    input  wire arrayCtl_t ctl,
    input  wire block_t    fillBlock,
    output logic       hit,
    output logic       victimDirty,
    output word_t      rdata,
    output block_t     victimBlock,
    output blockAddr_t victimAddr
);

    localparam int IndexBits = $clog2(NumSets);
    localparam int TagBits = $bits(blockAddr_t) - IndexBits;

    typedef logic [IndexBits-1:0] index_t;
    typedef logic [TagBits-1:0] tag_t;

    logic [NumSets-1:0] validBits;
    logic [NumSets-1:0] dirtyBits;
    tag_t tagMem [NumSets];
    block_t dataMem [NumSets];

    blockAddr_t reqBlockAddr;
    index_t index;
    tag_t reqTag;
    wordSel_t wordSel;
    block_t lineData;
    block_t mergedLine;

    // split the request address into index, tag and word position
    assign reqBlockAddr = req.addr[AddrBits-1:OffsetBits];
    assign index = reqBlockAddr[IndexBits-1:0];
    assign reqTag = reqBlockAddr[$bits(blockAddr_t)-1:IndexBits];
    assign wordSel = req.addr[OffsetBits-1 -: $bits(wordSel_t)];

    assign lineData = dataMem[index];

    assign hit = validBits[index] && (tagMem[index] == reqTag);
    assign victimDirty = validBits[index] && dirtyBits[index];
    assign rdata = lineData[wordSel*WordBits +: WordBits];

    // victim goes out as a whole block at its old address
    assign victimBlock = lineData;
    assign victimAddr = {tagMem[index], index};

    // only the selected bytes of the addressed word change
    always_comb begin
        mergedLine = lineData;
        for (int b = 0; b < BytesPerWord; b++) begin
            if (req.byteSel[b]) begin
                mergedLine[wordSel*WordBits + b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (ctl.fill) begin
            // a freshly filled line matches memory
            validBits[index] <= 1'b1;
            dirtyBits[index] <= 1'b0;
        end else if (ctl.hitWrite) begin
            dirtyBits[index] <= 1'b1;
        end
    end

    // the request is held during a miss, so its tag names the new line
    always_ff @(posedge clock) begin
        if (ctl.fill) begin
            dataMem[index] <= fillBlock;
            tagMem[index] <= reqTag;
        end else if (ctl.hitWrite) begin
            dataMem[index] <= mergedLine;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dcacheController.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheController import dcacheGeomPkg::*, dcacheBusPkg::*; (
    input  wire          clock,
    input  wire          reset,
    input  wire cpuReq_t req,
    input  wire          hit,
    input  wire          victimDirty,
    input  wire          memDone,
    output logic         stall,
    output arrayCtl_t    arrayCtl,
    output logic         memWrite,
    output logic         memRead
);

    missState_t state;
    missState_t nextState;

    logic validReq;
    logic missing;

    // read and write together is not a request
    assign validReq = req.read ^ req.write;
    assign missing = validReq && !hit;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (missing) begin
                    // a dirty victim must reach memory before the refill
                    nextState = victimDirty ? WriteBack : MemRead;
                end
            end
            WriteBack: begin
                if (memDone) begin
                    nextState = MemRead;
                end
            end
            MemRead: begin
                if (memDone) begin
                    nextState = Fill;
                end
            end
            Fill: begin
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    // stall is combinational so a miss holds the pipeline in its own cycle
    always_comb begin
        stall = missing;
        arrayCtl = '0;
        memWrite = 1'b0;
        memRead = 1'b0;
        case (state)
            Idle: begin
                arrayCtl.hitWrite = req.write && !req.read && hit;
            end
            WriteBack: begin
                stall = 1'b1;
                memWrite = 1'b1;
            end
            MemRead: begin
                stall = 1'b1;
                memRead = 1'b1;
            end
            Fill: begin
                stall = 1'b1;
                arrayCtl.fill = 1'b1;
            end
            default: begin
                stall = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/memBusMaster.sv
`timescale 1ns/1ps
`default_nettype none

module memBusMaster import dcacheGeomPkg::*, dcacheBusPkg::*; (
    input  wire             clock,
    input  wire             reset,
    input  wire             memWrite,
    input  wire             memRead,
    input  wire blockAddr_t victimAddr,
    input  wire block_t     victimBlock,
    input  wire blockAddr_t reqBlockAddr,
    input  wire wbSlave_t   wbIn,
    output wbMaster_t       wbOut,
    output logic            memDone,
    output block_t          fillBlock
);

    logic busCyc;
    logic busWe;
    blockAddr_t busAdr;
    block_t busDat;

    logic startCycle;
    logic ackSeen;

    // memDone high means the controller has not yet left its state
    assign startCycle = !busCyc && !memDone && (memWrite || memRead);
    assign ackSeen = busCyc && wbIn.ack;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            busCyc <= 1'b0;
            busWe <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= ackSeen;
            if (ackSeen) begin
                busCyc <= 1'b0;
                busWe <= 1'b0;
            end else if (startCycle) begin
                busCyc <= 1'b1;
                busWe <= memWrite;
            end
        end
    end

    // address and data stay put for the whole cycle
    always_ff @(posedge clock) begin
        if (startCycle) begin
            busAdr <= memWrite ? victimAddr : reqBlockAddr;
            busDat <= victimBlock;
        end
    end

    always_ff @(posedge clock) begin
        if (ackSeen && !busWe) begin
            fillBlock <= wbIn.dat;
        end
    end

    // stb follows cyc in classic single transfers
    assign wbOut = '{cyc: busCyc, stb: busCyc, we: busWe, adr: busAdr, dat: busDat};

endmodule

`default_nettype wire

// File: hdl/dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop import dcacheGeomPkg::*, dcacheBusPkg::*; #(
    parameter int NumSets = 16
) (
    input  wire           clock,
    input  wire           reset,
    input  wire cpuReq_t  req,
    output logic          stall,
    output word_t         rdata,
    output wbMaster_t     wbOut,
    input  wire wbSlave_t wbIn
);

    logic hit;
    logic victimDirty;
    arrayCtl_t arrayCtl;
    logic memWrite;
    logic memRead;
    logic memDone;
    block_t fillBlock;
    block_t victimBlock;
    blockAddr_t victimAddr;

    dcacheArray #(
        .NumSets(NumSets)
    ) u_dcacheArray (
        .clock(clock),
        .reset(reset),
        .req(req),
        .ctl(arrayCtl),
        .fillBlock(fillBlock),
        .hit(hit),
        .victimDirty(victimDirty),
        .rdata(rdata),
        .victimBlock(victimBlock),
        .victimAddr(victimAddr)
    );

    dcacheController u_dcacheController (
        .clock(clock),
        .reset(reset),
        .req(req),
        .hit(hit),
        .victimDirty(victimDirty),
        .memDone(memDone),
        .stall(stall),
        .arrayCtl(arrayCtl),
        .memWrite(memWrite),
        .memRead(memRead)
    );

    // refill address comes straight from the held request
    memBusMaster u_memBusMaster (
        .clock(clock),
        .reset(reset),
        .memWrite(memWrite),
        .memRead(memRead),
        .victimAddr(victimAddr),
        .victimBlock(victimBlock),
        .reqBlockAddr(req.addr[AddrBits-1:OffsetBits]),
        .wbIn(wbIn),
        .wbOut(wbOut),
        .memDone(memDone),
        .fillBlock(fillBlock)
    );

endmodule

`default_nettype wire

// File: sim/dcacheTop_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop_assertions import dcacheGeomPkg::*, dcacheBusPkg::*; (
    input wire             clock,
    input wire             reset,
    input wire wbMaster_t  wbOut,
    input wire wbSlave_t   wbIn,
    input wire             stall,
    input wire missState_t state
);

    int errorCount = 0;

    // no strobe outside a bus cycle
    assert property (@(posedge clock) disable iff (!reset) wbOut.stb |-> wbOut.cyc)
        else begin
            $error("stb high without cyc");
            errorCount++;
        end

    // transfer held until the slave acks
    assert property (@(posedge clock) disable iff (!reset)
        (wbOut.cyc && !wbIn.ack) |=> $stable({wbOut.adr, wbOut.we, wbOut.dat}))
        else begin
            $error("adr, we or dat changed before ack");
            errorCount++;
        end

    // a miss in progress always holds the pipeline
    assert property (@(posedge clock) disable iff (!reset) (state != Idle) |-> stall)
        else begin
            $error("controller busy while stall is low");
            errorCount++;
        end

endmodule

bind dcacheTop dcacheTop_assertions u_dcacheTopAssertions (
    .clock(clock),
    .reset(reset),
    .wbOut(wbOut),
    .wbIn(wbIn),
    .stall(stall),
    .state(u_dcacheController.state)
);

`default_nettype wire

// File: sim/dcacheTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTop_tb import dcacheGeomPkg::*, dcacheBusPkg::*; ();

    localparam int NumSets = 16;
    localparam int ClockPeriod = 4;
    localparam int SampleDelay = 1;
    localparam int NumBlocks = 4096;
    localparam int NumRequests = 16;
    localparam int TimeoutCycles = NumRequests * 40 + 10;
    // same index with the next tag
    localparam int SetStride = NumSets * (1 << OffsetBits);

    logic clock;
    logic reset;
    cpuReq_t req;
    logic stall;
    word_t rdata;
    wbMaster_t wbOut;
    wbSlave_t wbIn;

    logic [31:0] lfsrState;
    block_t memory [NumBlocks];
    word_t shadow [NumBlocks * WordsPerBlock];
    logic refValid [NumSets];
    logic refDirty [NumSets];
    blockAddr_t refLineAddr [NumSets];
    logic busWeLog [$];
    blockAddr_t busAdrLog [$];
    block_t busDatLog [$];
    string testName;

    dcacheTop #(
        .NumSets(NumSets)
    ) u_dcacheTop (
        .clock(clock),
        .reset(reset),
        .req(req),
        .stall(stall),
        .rdata(rdata),
        .wbOut(wbOut),
        .wbIn(wbIn)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(ClockPeriod / 2) clock = ~clock;
        end
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
        end
        return value;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic checkWord(input word_t expected, input word_t actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch in %s: expected %h, actual %h",
                testName, expected, actual));
        end
    endtask

    task automatic checkBlock(input block_t expected, input block_t actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch in %s: expected %h, actual %h",
                testName, expected, actual));
        end
    endtask

    task automatic checkAddr(input blockAddr_t expected, input blockAddr_t actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch in %s: expected %h, actual %h",
                testName, expected, actual));
        end
    endtask

    // Wishbone slave with a random ack delay of 1 to 4 cycles
    initial begin : memorySlave
        int delay;
        forever begin
            @(negedge clock);
            if (wbOut.cyc && wbOut.stb) begin
                delay = randomBits(2) + 1;
                repeat (delay - 1) begin
                    @(negedge clock);
                end
                busWeLog.push_back(wbOut.we);
                busAdrLog.push_back(wbOut.adr);
                busDatLog.push_back(wbOut.dat);
                if (wbOut.we) begin
                    memory[wbOut.adr] = wbOut.dat;
                end else begin
                    wbIn.dat = memory[wbOut.adr];
                end
                wbIn.ack = 1'b1;
                @(negedge clock);
                wbIn.ack = 1'b0;
            end
        end
    end

    // one request checked against the reference model once stall is low
    task automatic access(input logic read, input logic write, input addr_t addr,
                          input byteSel_t byteSel, input word_t wdata);
        blockAddr_t lineAddr;
        blockAddr_t victimLine;
        block_t victimData;
        int setIndex;
        int wordIndex;
        int stallCycles;
        int expectedCycles;
        logic expectMiss;
        logic expectWriteBack;

        lineAddr = addr[AddrBits-1:OffsetBits];
        setIndex = lineAddr % NumSets;
        wordIndex = addr >> 2;
        victimLine = refLineAddr[setIndex];
        for (int w = 0; w < WordsPerBlock; w++) begin
            victimData[w*WordBits +: WordBits] = shadow[victimLine*WordsPerBlock + w];
        end
        expectMiss = (read ^ write) && !(refValid[setIndex] && victimLine == lineAddr);
        expectWriteBack = expectMiss && refValid[setIndex] && refDirty[setIndex];
        expectedCycles = expectMiss ? (expectWriteBack ? 2 : 1) : 0;
        busWeLog.delete();
        busAdrLog.delete();
        busDatLog.delete();

        @(negedge clock);
        req = '{read: read, write: write, addr: addr, byteSel: byteSel, wdata: wdata};
        stallCycles = 0;
        #(SampleDelay);
        while (stall) begin
            @(negedge clock);
            #(SampleDelay);
            stallCycles++;
        end

        if (expectMiss != (stallCycles != 0)) begin
            failRun($sformatf("%s: stall did not follow the hit/miss outcome", testName));
        end
        if (busAdrLog.size() != expectedCycles) begin
            failRun($sformatf("%s: expected %0d bus cycles but saw %0d",
                testName, expectedCycles, busAdrLog.size()));
        end
        if (expectWriteBack) begin
            if (!busWeLog[0]) begin
                failRun($sformatf("%s: write-back cycle was not a write", testName));
            end
            checkAddr(victimLine, busAdrLog[0]);
            checkBlock(victimData, busDatLog[0]);
        end
        if (expectMiss) begin
            if (busWeLog[expectedCycles-1]) begin
                failRun($sformatf("%s: refill cycle was a write", testName));
            end
            checkAddr(lineAddr, busAdrLog[expectedCycles-1]);
            refValid[setIndex] = 1'b1;
            refDirty[setIndex] = 1'b0;
            refLineAddr[setIndex] = lineAddr;
        end
        if (read && !write) begin
            checkWord(shadow[wordIndex], rdata);
        end
        if (write && !read) begin
            for (int b = 0; b < BytesPerWord; b++) begin
                if (byteSel[b]) begin
                    shadow[wordIndex][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            refDirty[setIndex] = 1'b1;
        end
        if (u_dcacheTop.u_dcacheTopAssertions.errorCount != 0) begin
            failRun($sformatf("%s: a bus or stall assertion failed", testName));
        end
    endtask

    task automatic resetAndFirstRead();
        testName = "resetAndFirstRead";
        if (stall !== 1'b0 || wbOut.cyc !== 1'b0) begin
            failRun("stall or cyc is not low after reset");
        end
        access(1'b1, 1'b0, 16'h0124, 4'hf, '0);
    endtask

    task automatic readHitSameBlock();
        testName = "readHit";
        access(1'b1, 1'b0, 16'h0128, 4'hf, '0);
        access(1'b1, 1'b0, 16'h0124, 4'hf, '0);
    endtask

    task automatic partialWriteMerge();
        testName = "partialWrite";
        access(1'b0, 1'b1, 16'h0124, 4'b0101, randomBits(32));
        access(1'b0, 1'b1, 16'h0124, 4'b1000, randomBits(32));
        access(1'b0, 1'b1, 16'h012c, 4'b0011, randomBits(32));
        access(1'b1, 1'b0, 16'h0124, 4'hf, '0);
        access(1'b1, 1'b0, 16'h012c, 4'hf, '0);
    endtask

    task automatic dirtyEviction();
        testName = "dirtyEviction";
        access(1'b1, 1'b0, 16'h0124 + SetStride, 4'hf, '0);
    endtask

    task automatic cleanEvictionAndWriteMiss();
        testName = "cleanEvictionAndWriteMiss";
        access(1'b1, 1'b0, 16'h0124 + 2 * SetStride, 4'hf, '0);
        access(1'b0, 1'b1, 16'h0530, 4'b0110, randomBits(32));
        access(1'b1, 1'b0, 16'h0530, 4'hf, '0);
    endtask

    task automatic ignoredRequest();
        testName = "ignoredRequest";
        // the first would hit and the second would miss
        access(1'b1, 1'b1, 16'h0530, 4'hf, randomBits(32));
        access(1'b1, 1'b1, 16'h0744, 4'hf, randomBits(32));
        access(1'b1, 1'b0, 16'h0530, 4'hf, '0);
        access(1'b1, 1'b0, 16'h0744, 4'hf, '0);
    endtask

    initial begin
        reset = 1'b0;
        req = '0;
        wbIn = '0;
        lfsrState = 32'h1bc3d997;
        for (int b = 0; b < NumBlocks; b++) begin
            for (int w = 0; w < WordsPerBlock; w++) begin
                memory[b][w*WordBits +: WordBits] = randomBits(WordBits);
                shadow[b*WordsPerBlock + w] = memory[b][w*WordBits +: WordBits];
            end
        end
        for (int s = 0; s < NumSets; s++) begin
            refValid[s] = 1'b0;
            refDirty[s] = 1'b0;
            refLineAddr[s] = '0;
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        resetAndFirstRead();
        readHitSameBlock();
        partialWriteMerge();
        dirtyEviction();
        cleanEvictionAndWriteMiss();
        ignoredRequest();
        @(negedge clock);
        req = '0;
        if (u_dcacheTop.u_dcacheTopAssertions.errorCount == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            failRun("a bound assertion failed");
        end
    end

    initial begin : watchdog
        repeat (TimeoutCycles) @(posedge clock);
        failRun($sformatf("timeout after %0d cycles, a request never completed", TimeoutCycles));
    end

endmodule

`default_nettype wire

// File: dcacheTop.f
hdl/dcacheGeomPkg.sv
hdl/dcacheBusPkg.sv
hdl/dcacheArray.sv
hdl/dcacheController.sv
hdl/memBusMaster.sv
hdl/dcacheTop.sv
sim/dcacheTop_assertions.sv
sim/dcacheTop_tb.sv
